// File: Makefile
# Verilator build for the width_fifo subsystem

VERILATOR  = verilator
FILELIST   = filelist.f
TOP        = tb_top
RTL_TOP    = width_fifo_top
BUILD_DIR  = obj_dir
SIM_FLAGS  = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing -Wall
PASS_TEXT  = >>> PASS

.PHONY: all lint build sim clean

all: sim

# lint the design on its own
lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# status comes from the search for the pass line
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

// File: filelist.f
logic/width_fifo_pkg.sv
logic/wb_if.sv
logic/dp_ram.sv
logic/asym_dp_ram.sv
logic/fifo_ctrl.sv
logic/wb_push_port.sv
logic/wb_pop_port.sv
logic/width_fifo_top.sv
verification/tb_clock.sv
verification/tb_checker.sv
verification/tb_top.sv

// File: logic/asym_dp_ram.sv
`default_nettype none

// wide write, narrow read
// every bank holds one byte lane of each wide word, so a wide write
// lands in all banks at once and a narrow read picks one lane
module asym_dp_ram import width_fifo_pkg::*; (
   input  wire               clk,
   // wide write port
   input  wire               w_en,
   input  wire waddr_t       w_addr,
   input  wire wide_word_t   w_data,
   // narrow read port
   input  wire               r_en,
   input  wire raddr_t       r_addr,
   output narrow_word_t      r_data
);

   narrow_word_t               bank_rd [RATIO];
   // byte lane of the read in flight
   logic [RADDR_W-WADDR_W-1:0] bank_sel;

   for (genvar k = 0; k < RATIO; k++) begin : g_bank
      dp_ram bank (
         .clk    (clk),
         .w_en   (w_en),
         .w_addr (w_addr),
         .w_data (w_data[k*NARROW_W +: NARROW_W]),
         .r_en   (r_en),
         // word address is the upper part of the byte address
         .r_addr (r_addr[RADDR_W-1 -: WADDR_W]),
         .r_data (bank_rd[k])
      );
   end

   // lane select follows the bank read registers by one cycle
   always_ff @(posedge clk) begin
      if (r_en) begin
         bank_sel <= r_addr[RADDR_W-WADDR_W-1:0];
      end
   end

   // lane 0 is the least significant byte
   assign r_data = bank_rd[bank_sel];

endmodule

`default_nettype wire

// File: logic/dp_ram.sv
`default_nettype none

module dp_ram import width_fifo_pkg::*; (
   input  wire               clk,
   // write side
   input  wire               w_en,
   input  wire waddr_t       w_addr,
   input  wire narrow_word_t w_data,
   // read side
   input  wire               r_en,
   input  wire waddr_t       r_addr,
   output narrow_word_t      r_data
);

   narrow_word_t mem [WDEPTH];

   always_ff @(posedge clk) begin
      if (w_en) begin
         mem[w_addr] <= w_data;
      end
   end

   // output register holds its value between reads
   always_ff @(posedge clk) begin
      if (r_en) begin
         r_data <= mem[r_addr];
      end
   end

endmodule

`default_nettype wire

// File: logic/fifo_ctrl.sv
`default_nettype none

module fifo_ctrl import width_fifo_pkg::*; (
   input  wire    clk,
   input  wire    reset,
   input  wire    push,
   input  wire    pop,
   output waddr_t w_addr,
   output raddr_t r_addr,
   output count_t level,
   output logic   full,
   output logic   empty
);

   // write pointer counts words, read pointer counts bytes
   always_ff @(posedge clk) begin
      if (reset) begin
         w_addr <= '0;
      end else if (push) begin
         w_addr <= w_addr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         r_addr <= '0;
      end else if (pop) begin
         r_addr <= r_addr + 1'b1;
      end
   end

   // fill level in bytes
   always_ff @(posedge clk) begin
      if (reset) begin
         level <= '0;
      end else begin
         case ({push, pop})
            2'b10: begin
               level <= level + count_t'(RATIO);
            end
            2'b01: begin
               level <= level - 1'b1;
            end
            2'b11: begin
               level <= level + count_t'(RATIO - 1);
            end
            default: begin
               level <= level;
            end
         endcase
      end
   end

   // full once there is no room left for another whole word
   assign full  = (level > count_t'(WDEPTH * RATIO - RATIO));
   assign empty = (level == '0);

endmodule

`default_nettype wire

// File: logic/wb_if.sv
`default_nettype none

// wishbone classic, data bus sized for the wide side
interface wb_if import width_fifo_pkg::*; ();

   logic       cyc;
   logic       stb;
   logic       we;
   wide_word_t dat_m;
   wide_word_t dat_s;
   logic       ack;

   modport slave (
      input  cyc,
      input  stb,
      input  we,
      input  dat_m,
      output dat_s,
      output ack
   );

   modport master (
      output cyc,
      output stb,
      output we,
      output dat_m,
      input  dat_s,
      input  ack
   );

endinterface

`default_nettype wire

// File: logic/wb_pop_port.sv
`default_nettype none

module wb_pop_port import width_fifo_pkg::*; (
   input  wire          clk,
   input  wire          reset,
   wb_if.slave          bus,
   input  wire          empty,
   input  wire narrow_word_t r_data,
   output logic         pop
);

   pop_state_t   state;
   narrow_word_t rd_byte;
   logic         rd_req;
   logic         wr_req;

   assign rd_req = bus.cyc && bus.stb && !bus.we;
   assign wr_req = bus.cyc && bus.stb && bus.we;

   // one cycle pulse, also the RAM read enable
   assign pop = (state == POP_IDLE) && rd_req && !empty;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= POP_IDLE;
      end else begin
         case (state)
            POP_IDLE: begin
               if (pop) begin
                  state <= POP_FETCH;
               end else if (wr_req) begin
                  // writes on this port get acked and dropped
                  state <= POP_ACK;
               end
            end
            POP_FETCH: begin
               state <= POP_ACK;
            end
            POP_ACK: begin
               state <= POP_IDLE;
            end
            default: begin
               state <= POP_IDLE;
            end
         endcase
      end
   end

   // RAM output is valid in FETCH, capture it for the ack cycle
   always_ff @(posedge clk) begin
      if (state == POP_FETCH) begin
         rd_byte <= r_data;
      end else if (state == POP_IDLE && wr_req) begin
         rd_byte <= '0;
      end
   end

   assign bus.ack   = (state == POP_ACK);
   assign bus.dat_s = wide_word_t'(rd_byte);

endmodule

`default_nettype wire

// File: logic/wb_push_port.sv
`default_nettype none

module wb_push_port import width_fifo_pkg::*; (
   input  wire        clk,
   input  wire        reset,
   wb_if.slave        bus,
   input  wire        full,
   output logic       push,
   output wide_word_t w_data
);

   logic req;
   logic ack_q;

   // new write request, not the one being acked right now
   assign req = bus.cyc && bus.stb && bus.we && !ack_q;

   // held off while full
   always_ff @(posedge clk) begin
      if (reset) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req && !full;
      end
   end

   assign bus.ack = ack_q;

   // master keeps dat_m stable until it sees ack, so the
   // word is written in the ack cycle itself
   assign push   = ack_q;
   assign w_data = bus.dat_m;

   // write-only port
   assign bus.dat_s = '0;

endmodule

`default_nettype wire

// File: logic/width_fifo_pkg.sv
`default_nettype none

package width_fifo_pkg;

   // producer writes wide words, consumer reads narrow bytes
   localparam int WIDE_W   = 32;
   localparam int NARROW_W = 8;
   localparam int RATIO    = WIDE_W / NARROW_W;

   // capacity in wide words
   localparam int WDEPTH  = 16;
   localparam int WADDR_W = $clog2(WDEPTH);
   localparam int RADDR_W = WADDR_W + $clog2(RATIO);

   // byte count, one extra bit so a completely full buffer fits
   localparam int COUNT_W = RADDR_W + 1;

   typedef logic [WIDE_W-1:0]   wide_word_t;
   typedef logic [NARROW_W-1:0] narrow_word_t;
   typedef logic [WADDR_W-1:0]  waddr_t;
   typedef logic [RADDR_W-1:0]  raddr_t;
   typedef logic [COUNT_W-1:0]  count_t;

   // read port sequencing
   typedef enum logic [1:0] {
      POP_IDLE,
      POP_FETCH,
      POP_ACK
   } pop_state_t;

endpackage

`default_nettype wire

// File: logic/width_fifo_top.sv
`default_nettype none

module width_fifo_top import width_fifo_pkg::*; (
   input  wire               clk,
   input  wire               reset,
   // producer, 32-bit words
   input  wire               wr_cyc,
   input  wire               wr_stb,
   input  wire               wr_we,
   input  wire wide_word_t   wr_dat,
   output logic              wr_ack,
   // consumer, bytes
   input  wire               rd_cyc,
   input  wire               rd_stb,
   input  wire               rd_we,
   output narrow_word_t      rd_dat,
   output logic              rd_ack,
   // bytes held
   output count_t            level
);

   wb_if wr_bus ();
   wb_if rd_bus ();

   logic         push;
   logic         pop;
   logic         full;
   logic         empty;
   wide_word_t   w_data;
   waddr_t       w_addr;
   raddr_t       r_addr;
   narrow_word_t r_data;

   // master side of the write bus
   assign wr_bus.cyc   = wr_cyc;
   assign wr_bus.stb   = wr_stb;
   assign wr_bus.we    = wr_we;
   assign wr_bus.dat_m = wr_dat;
   assign wr_ack       = wr_bus.ack;

   // master side of the read bus, no write data on this side
   assign rd_bus.cyc   = rd_cyc;
   assign rd_bus.stb   = rd_stb;
   assign rd_bus.we    = rd_we;
   assign rd_bus.dat_m = '0;
   assign rd_ack       = rd_bus.ack;
   assign rd_dat       = rd_bus.dat_s[NARROW_W-1:0];

   wb_push_port push_port (
      .clk    (clk),
      .reset  (reset),
      .bus    (wr_bus.slave),
      .full   (full),
      .push   (push),
      .w_data (w_data)
   );

   wb_pop_port pop_port (
      .clk    (clk),
      .reset  (reset),
      .bus    (rd_bus.slave),
      .empty  (empty),
      .r_data (r_data),
      .pop    (pop)
   );

   fifo_ctrl ctrl (
      .clk    (clk),
      .reset  (reset),
      .push   (push),
      .pop    (pop),
      .w_addr (w_addr),
      .r_addr (r_addr),
      .level  (level),
      .full   (full),
      .empty  (empty)
   );

   asym_dp_ram ram (
      .clk    (clk),
      .w_en   (push),
      .w_addr (w_addr),
      .w_data (w_data),
      .r_en   (pop),
      .r_addr (r_addr),
      .r_data (r_data)
   );

endmodule

`default_nettype wire

// File: verification/tb_checker.sv
`default_nettype none

module tb_checker import width_fifo_pkg::*; (
   input  wire               clk,
   input  wire               reset,
   input  wire               wr_cyc,
   input  wire               wr_stb,
   input  wire               wr_we,
   input  wire wide_word_t   wr_dat,
   input  wire               wr_ack,
   input  wire               rd_cyc,
   input  wire               rd_stb,
   input  wire               rd_we,
   input  wire narrow_word_t rd_dat,
   input  wire               rd_ack,
   input  wire count_t       level,
   input  int                test_num,
   input  wire               test_end,
   input  wire               all_done,
   output int                errors
);

   // longest wait for an ack before it counts as lost
   localparam int ACK_LIMIT = 100;

   narrow_word_t model_q [$];
   narrow_word_t exp_byte;
   int           pushed = 0;
   int           popped = 0;
   int           checks = 0;
   int           error_count = 0;
   int           test_base = 0;
   int           wr_wait = 0;
   int           rd_wait = 0;
   logic         in_reset = 1'b0;

   assign errors = error_count;

   // a wide word leaves the FIFO as four bytes with the lowest byte first
   function automatic void model_push(input wide_word_t word);
      for (int k = 0; k < RATIO; k++) begin
         model_q.push_back(word[k*NARROW_W +: NARROW_W]);
      end
   endfunction

   function automatic void check_level();
      count_t exp_level;
      exp_level = count_t'(RATIO * pushed - popped);
      checks++;
      if (level !== exp_level) begin
         error_count++;
         $display("ERROR level: got 0x%02h, expected 0x%02h", level, exp_level);
      end
   endfunction

   function automatic string test_name(input int n);
      case (n)
         1:       return "byte order";
         2:       return "write back-pressure";
         3:       return "read back-pressure";
         4:       return "random traffic";
         5:       return "reset";
         default: return "unknown";
      endcase
   endfunction

   always @(negedge clk) begin
      if (reset) begin
         // outputs settle one edge after reset is first seen
         if (in_reset) begin
            checks++;
            if (level !== '0) begin
               error_count++;
               $display("ERROR level in reset: got 0x%02h, expected 0x00", level);
            end
            if (wr_ack !== 1'b0) begin
               error_count++;
               $display("ERROR wr_ack in reset: got 0x%0h, expected 0x0", wr_ack);
            end
            if (rd_ack !== 1'b0) begin
               error_count++;
               $display("ERROR rd_ack in reset: got 0x%0h, expected 0x0", rd_ack);
            end
         end
         model_q.delete();
         pushed   = 0;
         popped   = 0;
         wr_wait  = 0;
         rd_wait  = 0;
         in_reset = 1'b1;
      end else begin
         in_reset = 1'b0;
         // read first since a byte handed out now was stored earlier
         if (rd_ack === 1'b1 && rd_we === 1'b0) begin
            popped++;
            if (model_q.size() == 0) begin
               error_count++;
               $display("read acked while the FIFO should be empty");
            end else begin
               exp_byte = model_q.pop_front();
               checks++;
               if (rd_dat !== exp_byte) begin
                  error_count++;
                  $display("ERROR rd_dat: got 0x%02h, expected 0x%02h", rd_dat, exp_byte);
               end
            end
            check_level();
         end
         if (wr_ack === 1'b1) begin
            if (level > count_t'(WDEPTH * RATIO - RATIO)) begin
               error_count++;
               $display("write acked while the FIFO had no room for a whole word");
            end
            // with the read side idle no pop can be in flight
            if (rd_stb !== 1'b1) begin
               check_level();
            end
            model_push(wr_dat);
            pushed++;
         end
         if (wr_cyc && wr_stb && wr_we && wr_ack !== 1'b1) begin
            wr_wait++;
            if (wr_wait == ACK_LIMIT) begin
               error_count++;
               $display("write request got no ack within %0d cycles", ACK_LIMIT);
            end
         end else begin
            wr_wait = 0;
         end
         if (rd_cyc && rd_stb && rd_ack !== 1'b1) begin
            rd_wait++;
            if (rd_wait == ACK_LIMIT) begin
               error_count++;
               $display("read request got no ack within %0d cycles", ACK_LIMIT);
            end
         end else begin
            rd_wait = 0;
         end
      end
      if (test_end) begin
         check_level();
         $display("test %0d (%s): %0d errors", test_num, test_name(test_num),
                  error_count - test_base);
         test_base = error_count;
      end
      if (all_done) begin
         $display("%0d checks, %0d errors", checks, error_count);
      end
   end

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
`default_nettype none

module tb_clock (
   output logic clk
);

   localparam int HALF_PERIOD = 4;

   initial begin
      clk = 1'b0;
   end

   always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

// File: verification/tb_top.sv
`default_nettype none

module tb_top import width_fifo_pkg::*; ();

   localparam int RAND_WORDS  = 40;
   // words and bytes moved over all five tests
   localparam int TOTAL_XFERS = 320;
   localparam int GIVE_UP     = 110;

   logic         clk;
   logic         reset;
   logic         wr_cyc;
   logic         wr_stb;
   logic         wr_we;
   wide_word_t   wr_dat;
   logic         wr_ack;
   logic         rd_cyc;
   logic         rd_stb;
   logic         rd_we;
   narrow_word_t rd_dat;
   logic         rd_ack;
   count_t       level;
   int           test_num;
   logic         test_end;
   logic         all_done;
   int           errors;
   logic [31:0]  rng;
   logic [31:0]  word;
   // consumer gaps in the random test
   logic [31:0]  gap_rng;

   tb_clock clk_gen (
      .clk (clk)
   );

   width_fifo_top dut0 (
      .clk    (clk),
      .reset  (reset),
      .wr_cyc (wr_cyc),
      .wr_stb (wr_stb),
      .wr_we  (wr_we),
      .wr_dat (wr_dat),
      .wr_ack (wr_ack),
      .rd_cyc (rd_cyc),
      .rd_stb (rd_stb),
      .rd_we  (rd_we),
      .rd_dat (rd_dat),
      .rd_ack (rd_ack),
      .level  (level)
   );

   tb_checker chk0 (
      .clk      (clk),
      .reset    (reset),
      .wr_cyc   (wr_cyc),
      .wr_stb   (wr_stb),
      .wr_we    (wr_we),
      .wr_dat   (wr_dat),
      .wr_ack   (wr_ack),
      .rd_cyc   (rd_cyc),
      .rd_stb   (rd_stb),
      .rd_we    (rd_we),
      .rd_dat   (rd_dat),
      .rd_ack   (rd_ack),
      .level    (level),
      .test_num (test_num),
      .test_end (test_end),
      .all_done (all_done),
      .errors   (errors)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic next_rand(output logic [31:0] value);
      rng   = xorshift32(rng);
      value = rng;
   endtask

   // classic cycle held until ack is seen
   task automatic write_word(input wide_word_t data);
      int waited;
      waited = 0;
      @(posedge clk);
      wr_cyc <= 1'b1;
      wr_stb <= 1'b1;
      wr_we  <= 1'b1;
      wr_dat <= data;
      @(negedge clk);
      while (wr_ack !== 1'b1 && waited < GIVE_UP) begin
         @(negedge clk);
         waited++;
      end
      @(posedge clk);
      wr_cyc <= 1'b0;
      wr_stb <= 1'b0;
      wr_we  <= 1'b0;
   endtask

   task automatic read_byte();
      int waited;
      waited = 0;
      @(posedge clk);
      rd_cyc <= 1'b1;
      rd_stb <= 1'b1;
      rd_we  <= 1'b0;
      @(negedge clk);
      while (rd_ack !== 1'b1 && waited < GIVE_UP) begin
         @(negedge clk);
         waited++;
      end
      @(posedge clk);
      rd_cyc <= 1'b0;
      rd_stb <= 1'b0;
   endtask

   task automatic finish_test(input int n);
      @(posedge clk);
      test_num <= n;
      test_end <= 1'b1;
      @(posedge clk);
      test_end <= 1'b0;
   endtask

   // watchdog
   initial begin
      repeat (TOTAL_XFERS * 20 + 500) @(posedge clk);
      $display("watchdog expired before the tests completed");
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      rng      = 32'h0f8e_1167;
      gap_rng  = '0;
      reset    = 1'b1;
      wr_cyc   = 1'b0;
      wr_stb   = 1'b0;
      wr_we    = 1'b0;
      wr_dat   = '0;
      rd_cyc   = 1'b0;
      rd_stb   = 1'b0;
      rd_we    = 1'b0;
      test_num = 0;
      test_end = 1'b0;
      all_done = 1'b0;
      repeat (8) @(posedge clk);
      reset <= 1'b0;

      // four words out as sixteen bytes
      repeat (4) begin
         next_rand(word);
         write_word(word);
      end
      repeat (16) read_byte();
      finish_test(1);

      // full FIFO holds off the seventeenth word
      repeat (WDEPTH) begin
         next_rand(word);
         write_word(word);
      end
      next_rand(word);
      fork
         write_word(word);
         begin
            repeat (8) @(posedge clk);
            repeat (RATIO) read_byte();
         end
      join
      finish_test(2);

      // drain and then a read waits on the empty FIFO
      repeat (WDEPTH * RATIO) read_byte();
      next_rand(word);
      fork
         read_byte();
         begin
            repeat (12) @(posedge clk);
            write_word(word);
         end
      join
      repeat (RATIO - 1) read_byte();
      finish_test(3);

      // independent producer and consumer
      next_rand(gap_rng);
      fork
         begin : producer
            logic [31:0] r;
            for (int i = 0; i < RAND_WORDS; i++) begin
               next_rand(r);
               repeat (r[2:0]) @(posedge clk);
               next_rand(r);
               write_word(r);
            end
         end
         begin : consumer
            for (int i = 0; i < RAND_WORDS * RATIO; i++) begin
               gap_rng = xorshift32(gap_rng);
               repeat (gap_rng[2:0]) @(posedge clk);
               read_byte();
            end
         end
      join

      finish_test(4);

      // reset with data held and then one clean round trip
      repeat (3) begin
         next_rand(word);
         write_word(word);
      end
      repeat (2) read_byte();
      @(posedge clk);
      reset <= 1'b1;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      next_rand(word);
      write_word(word);
      repeat (RATIO) read_byte();
      finish_test(5);

      @(posedge clk);
      all_done <= 1'b1;
      @(posedge clk);
      all_done <= 1'b0;
      @(posedge clk);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
